//--- logic/memCtrl_defines.svh
`ifndef MEM_CTRL_DEFINES_SVH
`define MEM_CTRL_DEFINES_SVH

// byte-wide RAM bus
`define ADDR_WIDTH 32
`define BYTE_WIDTH 8

// client word and transfer length
`define WORD_WIDTH 32
`define BYTES_PER_WORD 4
// counts 0 to 4
`define LEN_WIDTH 3

`endif

//--- logic/memCtrlPkg.sv
`include "memCtrl_defines.svh"

package memCtrlPkg;

    // what the accepted request does on the RAM bus
    typedef enum logic [1:0] {
        kindFetch = 2'd0,
        kindLoad  = 2'd1,
        kindStore = 2'd2
    } reqKind_t;

    // byte lanes of a word, lane 0 at the base address
    typedef logic [`BYTES_PER_WORD-1:0][`BYTE_WIDTH-1:0] wordBytes_t;

endpackage

//--- logic/reqArbiter.sv
`timescale 1ns/100ps
`include "memCtrl_defines.svh"

module reqArbiter (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_pause,
    input  logic                         i_fetchValid,
    input  logic [`ADDR_WIDTH-1:0]       i_fetchAddr,
    input  logic                         i_dataValid,
    input  logic                         i_dataStore,
    input  logic [`LEN_WIDTH-1:0]        i_dataLen,
    input  logic [`ADDR_WIDTH-1:0]       i_dataAddr,
    input  logic [`WORD_WIDTH-1:0]       i_dataWdata,
    input  logic                         i_reqReady,
    input  logic                         i_txnDone,
    output logic                         o_fetchReady,
    output logic                         o_dataReady,
    output logic                         o_reqValid,
    output memCtrlPkg::reqKind_t         o_reqKind,
    output logic [`ADDR_WIDTH-1:0]       o_reqAddr,
    output logic [`LEN_WIDTH-1:0]        o_reqLen,
    output memCtrlPkg::wordBytes_t       o_reqWdata
);

    logic outOfReset;
    logic busy;
    logic canAccept;
    logic dataAccept;
    logic fetchAccept;

    // data port has priority over fetch
    assign canAccept   = outOfReset && !busy && !i_pause;
    assign o_dataReady  = canAccept;
    assign o_fetchReady = canAccept && !i_dataValid;
    assign dataAccept   = o_dataReady && i_dataValid;
    assign fetchAccept  = o_fetchReady && i_fetchValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            outOfReset <= 1'b0;
            busy       <= 1'b0;
            o_reqValid <= 1'b0;
        end else begin
            outOfReset <= 1'b1;
            if (dataAccept || fetchAccept) begin
                busy       <= 1'b1;
                o_reqValid <= 1'b1;
            end else begin
                // sequencer takes it on the last byte
                if (o_reqValid && i_reqReady) begin
                    o_reqValid <= 1'b0;
                end
                // busy until the client has the response
                if (i_txnDone) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dataAccept) begin
            o_reqKind  <= i_dataStore ? memCtrlPkg::kindStore : memCtrlPkg::kindLoad;
            o_reqAddr  <= i_dataAddr;
            o_reqLen   <= i_dataLen;
            o_reqWdata <= i_dataWdata;
        end else if (fetchAccept) begin
            // fetch is always a full word
            o_reqKind <= memCtrlPkg::kindFetch;
            o_reqAddr <= i_fetchAddr;
            o_reqLen  <= `LEN_WIDTH'(`BYTES_PER_WORD);
        end
    end

endmodule

//--- logic/busSequencer.sv
`timescale 1ns/100ps
`include "memCtrl_defines.svh"

module busSequencer (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  i_pause,
    input  logic                                  i_reqValid,
    input  memCtrlPkg::reqKind_t                  i_reqKind,
    input  logic [`ADDR_WIDTH-1:0]                i_reqAddr,
    input  logic [`LEN_WIDTH-1:0]                 i_reqLen,
    input  memCtrlPkg::wordBytes_t                i_reqWdata,
    output logic                                  o_reqReady,
    output logic [`ADDR_WIDTH-1:0]                o_memAddr,
    output logic                                  o_memWrite,
    output logic [`BYTE_WIDTH-1:0]                o_memWdata,
    output logic                                  o_byteValid,
    output logic [$clog2(`BYTES_PER_WORD)-1:0]    o_byteIndex,
    output logic                                  o_lastIssued,
    output memCtrlPkg::reqKind_t                  o_lastKind,
    output logic [`LEN_WIDTH-1:0]                 o_lastLen
);

    localparam int lenW  = `LEN_WIDTH;
    localparam int addrW = `ADDR_WIDTH;

    logic [$clog2(`BYTES_PER_WORD)-1:0] cnt;
    logic issue;
    logic isStore;
    logic lastByte;

    // one byte per unpaused cycle while a request is pending
    assign issue    = i_reqValid && !i_pause;
    assign isStore  = i_reqKind == memCtrlPkg::kindStore;
    assign lastByte = issue && (lenW'(cnt) + 1'b1 == i_reqLen);

    assign o_reqReady = lastByte;

    // counter is frozen in a pause so the address holds
    assign o_memAddr  = i_reqAddr + addrW'(cnt);
    assign o_memWrite = issue && isStore;
    assign o_memWdata = i_reqWdata[cnt];

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt          <= '0;
            o_byteValid  <= 1'b0;
            o_lastIssued <= 1'b0;
        end else begin
            if (issue) begin
                cnt <= lastByte ? '0 : cnt + 1'b1;
            end
            // read data shows up on the bus next cycle
            o_byteValid  <= issue && !isStore;
            o_lastIssued <= lastByte;
        end
    end

    always_ff @(posedge clk) begin
        o_byteIndex <= cnt;
        if (lastByte) begin
            o_lastKind <= i_reqKind;
            o_lastLen  <= i_reqLen;
        end
    end

endmodule

//--- logic/wordAssembler.sv
`timescale 1ns/100ps
`include "memCtrl_defines.svh"

module wordAssembler (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [`BYTE_WIDTH-1:0]                i_memRdata,
    input  logic                                  i_byteValid,
    input  logic [$clog2(`BYTES_PER_WORD)-1:0]    i_byteIndex,
    input  logic                                  i_lastIssued,
    input  memCtrlPkg::reqKind_t                  i_lastKind,
    input  logic [`LEN_WIDTH-1:0]                 i_lastLen,
    input  logic                                  i_fetchRespReady,
    input  logic                                  i_dataRespReady,
    output logic                                  o_fetchRespValid,
    output logic [`WORD_WIDTH-1:0]                o_fetchInst,
    output logic                                  o_dataRespValid,
    output logic [`WORD_WIDTH-1:0]                o_dataRdata,
    output logic                                  o_txnDone
);

    memCtrlPkg::wordBytes_t word;
    memCtrlPkg::reqKind_t   txnKind;
    logic [`LEN_WIDTH-1:0]  pendLen;
    logic [`LEN_WIDTH-1:0]  rxCount;
    logic respValid;
    logic pending;
    logic isFetch;
    logic take;

    assign isFetch = txnKind == memCtrlPkg::kindFetch;

    // response goes to the port that issued it
    assign o_fetchRespValid = respValid && isFetch;
    assign o_dataRespValid  = respValid && !isFetch;
    assign o_fetchInst      = word;
    assign o_dataRdata      = word;

    assign take = (o_fetchRespValid && i_fetchRespReady)
               || (o_dataRespValid && i_dataRespReady);
    assign o_txnDone = take;

    always_ff @(posedge clk) begin
        if (rst) begin
            respValid <= 1'b0;
            pending   <= 1'b0;
            rxCount   <= '0;
            word      <= '0;
        end else begin
            // lanes not written stay zero, which zero-extends short loads
            if (take) begin
                respValid <= 1'b0;
                rxCount   <= '0;
                word      <= '0;
            end else if (i_byteValid) begin
                word[i_byteIndex] <= i_memRdata;
                rxCount           <= rxCount + 1'b1;
            end

            if (i_lastIssued) begin
                // stores answer at once with zero data
                if (i_lastKind == memCtrlPkg::kindStore) begin
                    respValid <= 1'b1;
                end else begin
                    pending <= 1'b1;
                end
            end else if (pending && rxCount == pendLen) begin
                pending   <= 1'b0;
                respValid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_lastIssued) begin
            txnKind <= i_lastKind;
            pendLen <= i_lastLen;
        end
    end

endmodule

//--- logic/memCtrl.sv
`timescale 1ns/100ps
`include "memCtrl_defines.svh"

module memCtrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_rdy,
    input  logic                      i_ioBufferFull,
    input  logic                      i_fetchValid,
    input  logic [`ADDR_WIDTH-1:0]    i_fetchAddr,
    output logic                      o_fetchReady,
    output logic                      o_fetchRespValid,
    output logic [`WORD_WIDTH-1:0]    o_fetchInst,
    input  logic                      i_fetchRespReady,
    input  logic                      i_dataValid,
    input  logic                      i_dataStore,
    input  logic [`LEN_WIDTH-1:0]     i_dataLen,
    input  logic [`ADDR_WIDTH-1:0]    i_dataAddr,
    input  logic [`WORD_WIDTH-1:0]    i_dataWdata,
    output logic                      o_dataReady,
    output logic                      o_dataRespValid,
    output logic [`WORD_WIDTH-1:0]    o_dataRdata,
    input  logic                      i_dataRespReady,
    output logic [`ADDR_WIDTH-1:0]    o_memAddr,
    output logic                      o_memWrite,
    output logic [`BYTE_WIDTH-1:0]    o_memWdata,
    input  logic [`BYTE_WIDTH-1:0]    i_memRdata
);

    logic pause;
    logic reqValid;
    logic reqReady;
    memCtrlPkg::reqKind_t reqKind;
    logic [`ADDR_WIDTH-1:0] reqAddr;
    logic [`LEN_WIDTH-1:0] reqLen;
    memCtrlPkg::wordBytes_t reqWdata;
    logic byteValid;
    logic [$clog2(`BYTES_PER_WORD)-1:0] byteIndex;
    logic lastIssued;
    memCtrlPkg::reqKind_t lastKind;
    logic [`LEN_WIDTH-1:0] lastLen;
    logic txnDone;

    // core stall or full I/O buffer freezes the bus
    assign pause = !i_rdy || i_ioBufferFull;

    reqArbiter arbiter_i (
        .clk(clk), .rst(rst), .i_pause(pause),
        .i_fetchValid(i_fetchValid), .i_fetchAddr(i_fetchAddr),
        .i_dataValid(i_dataValid), .i_dataStore(i_dataStore), .i_dataLen(i_dataLen),
        .i_dataAddr(i_dataAddr), .i_dataWdata(i_dataWdata),
        .i_reqReady(reqReady), .i_txnDone(txnDone),
        .o_fetchReady(o_fetchReady), .o_dataReady(o_dataReady),
        .o_reqValid(reqValid), .o_reqKind(reqKind), .o_reqAddr(reqAddr),
        .o_reqLen(reqLen), .o_reqWdata(reqWdata)
    );

    busSequencer sequencer_i (
        .clk(clk), .rst(rst), .i_pause(pause),
        .i_reqValid(reqValid), .i_reqKind(reqKind), .i_reqAddr(reqAddr),
        .i_reqLen(reqLen), .i_reqWdata(reqWdata), .o_reqReady(reqReady),
        .o_memAddr(o_memAddr), .o_memWrite(o_memWrite), .o_memWdata(o_memWdata),
        .o_byteValid(byteValid), .o_byteIndex(byteIndex),
        .o_lastIssued(lastIssued), .o_lastKind(lastKind), .o_lastLen(lastLen)
    );

    wordAssembler assembler_i (
        .clk(clk), .rst(rst), .i_memRdata(i_memRdata),
        .i_byteValid(byteValid), .i_byteIndex(byteIndex),
        .i_lastIssued(lastIssued), .i_lastKind(lastKind), .i_lastLen(lastLen),
        .i_fetchRespReady(i_fetchRespReady), .i_dataRespReady(i_dataRespReady),
        .o_fetchRespValid(o_fetchRespValid), .o_fetchInst(o_fetchInst),
        .o_dataRespValid(o_dataRespValid), .o_dataRdata(o_dataRdata),
        .o_txnDone(txnDone)
    );

endmodule

//--- dv/memCtrl_asserts.sv
`timescale 1ns/100ps
`include "memCtrl_defines.svh"

module memCtrl_asserts (
    input logic                   clk,
    input logic                   rst,
    input logic                   i_pause,
    input logic [`ADDR_WIDTH-1:0] i_memAddr,
    input logic                   i_memWrite,
    input logic                   i_fetchReady,
    input logic                   i_dataReady,
    input logic                   i_fetchRespValid,
    input logic                   i_fetchRespReady,
    input logic [`WORD_WIDTH-1:0] i_fetchInst,
    input logic                   i_dataRespValid,
    input logic                   i_dataRespReady,
    input logic [`WORD_WIDTH-1:0] i_dataRdata
);

    int failCount = 0;

    function automatic void flagFailure(input string what);
        $error("%s", what);
        failCount++;
    endfunction

    // bus frozen while paused
    noWriteInPause: assert property (@(posedge clk) disable iff (rst)
        i_pause |-> !i_memWrite) else flagFailure("write strobe during a pause");
    addrHeldInPause: assert property (@(posedge clk) disable iff (rst)
        i_pause && $past(i_pause) |-> $stable(i_memAddr))
        else flagFailure("memory address moved during a pause");

    quietAfterReset: assert property (@(posedge clk) rst |=> !i_fetchRespValid
        && !i_dataRespValid && !i_memWrite && !i_fetchReady && !i_dataReady)
        else flagFailure("outputs not idle after reset");
    oneRespAtATime: assert property (@(posedge clk) disable iff (rst)
        !(i_fetchRespValid && i_dataRespValid)) else flagFailure("both response valids high");

    // response held until taken, and no new request meanwhile
    fetchRespHeld: assert property (@(posedge clk) disable iff (rst)
        i_fetchRespValid && !i_fetchRespReady |=> i_fetchRespValid && $stable(i_fetchInst))
        else flagFailure("fetch response changed before it was taken");
    dataRespHeld: assert property (@(posedge clk) disable iff (rst)
        i_dataRespValid && !i_dataRespReady |=> i_dataRespValid && $stable(i_dataRdata))
        else flagFailure("data response changed before it was taken");
    noAcceptDuringResp: assert property (@(posedge clk) disable iff (rst)
        i_fetchRespValid || i_dataRespValid |-> !i_fetchReady && !i_dataReady)
        else flagFailure("request ready while a response is pending");

endmodule

bind memCtrl memCtrl_asserts protoChecks_i (
    .clk(clk), .rst(rst), .i_pause(pause), .i_memAddr(o_memAddr), .i_memWrite(o_memWrite),
    .i_fetchReady(o_fetchReady), .i_dataReady(o_dataReady),
    .i_fetchRespValid(o_fetchRespValid), .i_fetchRespReady(i_fetchRespReady),
    .i_fetchInst(o_fetchInst), .i_dataRespValid(o_dataRespValid),
    .i_dataRespReady(i_dataRespReady), .i_dataRdata(o_dataRdata)
);

//--- dv/memCtrl_tb.sv
`timescale 1ns/100ps
`include "memCtrl_defines.svh"

module memCtrl_tb;

    // about 60 transactions of up to 30 cycles, doubled
    localparam int maxTxns       = 60;
    localparam int maxTxnCycles  = 30;
    localparam int timeoutCycles = 2 * maxTxns * maxTxnCycles + 400;

    logic clk, rst, i_rdy, i_ioBufferFull;
    logic i_fetchValid, o_fetchReady, o_fetchRespValid, i_fetchRespReady;
    logic i_dataValid, i_dataStore, o_dataReady, o_dataRespValid, i_dataRespReady;
    logic [`ADDR_WIDTH-1:0] i_fetchAddr, i_dataAddr, o_memAddr;
    logic [`WORD_WIDTH-1:0] o_fetchInst, i_dataWdata, o_dataRdata;
    logic [`LEN_WIDTH-1:0] i_dataLen;
    logic o_memWrite;
    logic [`BYTE_WIDTH-1:0] o_memWdata, i_memRdata;

    logic [7:0] ramMem [256];
    logic [7:0] refMem [256];
    logic [7:0] rdAddr;
    logic [`ADDR_WIDTH-1:0] wrAddrQ [$];
    logic [`BYTE_WIDTH-1:0] wrDataQ [$];
    int seed = 32'h61c1_0a7f;
    int cycles = 0;
    int errorCount = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int testErrBase = 0;

    memCtrl dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    // byte RAM, read data one cycle after the address
    always @(posedge clk) begin
        if (o_memWrite) begin
            ramMem[o_memAddr[7:0]] <= o_memWdata;
        end
        rdAddr <= o_memAddr[7:0];
    end

    always @(negedge clk) i_memRdata <= ramMem[rdAddr];

    always @(posedge clk) begin
        if (!rst && o_memWrite) begin
            wrAddrQ.push_back(o_memAddr);
            wrDataQ.push_back(o_memWdata);
        end
    end

    function automatic int totalErrors();
        return errorCount + dut_i.protoChecks_i.failCount;
    endfunction

    function automatic int randomLen();
        int pick;
        pick = $unsigned($random(seed)) % 3;
        return (pick == 2) ? 4 : pick + 1;
    endfunction

    // little-endian bytes from the reference copy, upper lanes zero
    function automatic logic [31:0] expectedWord(input logic [31:0] addr, input int len);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < len; i++) begin
            w[8*i +: 8] = refMem[8'(addr + 32'(i))];
        end
        return w;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic dataTxn(input logic store, input int len, input logic [31:0] addr,
                           input logic [31:0] wdata, input int holdOff,
                           output logic [31:0] rdata);
        @(negedge clk);
        i_dataValid = 1'b1;
        i_dataStore = store;
        i_dataLen   = 3'(len);
        i_dataAddr  = addr;
        i_dataWdata = wdata;
        #1;
        while (!o_dataReady) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        i_dataValid     = 1'b0;
        i_dataRespReady = (holdOff == 0);
        #1;
        while (!o_dataRespValid) begin
            @(negedge clk);
            #1;
        end
        repeat (holdOff) @(negedge clk);
        i_dataRespReady = 1'b1;
        rdata = o_dataRdata;
        @(negedge clk);
        i_dataRespReady = 1'b0;
    endtask

    task automatic fetchTxn(input logic [31:0] addr, input int holdOff,
                            output logic [31:0] inst);
        @(negedge clk);
        i_fetchValid = 1'b1;
        i_fetchAddr  = addr;
        #1;
        while (!o_fetchReady) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        i_fetchValid     = 1'b0;
        i_fetchRespReady = (holdOff == 0);
        #1;
        while (!o_fetchRespValid) begin
            @(negedge clk);
            #1;
        end
        repeat (holdOff) @(negedge clk);
        i_fetchRespReady = 1'b1;
        inst = o_fetchInst;
        @(negedge clk);
        i_fetchRespReady = 1'b0;
    endtask

    task automatic loadAndCheck(input int len, input logic [31:0] addr, input int holdOff);
        logic [31:0] rdata;
        dataTxn(1'b0, len, addr, 32'h0, holdOff, rdata);
        checkValue("o_dataRdata", rdata, expectedWord(addr, len));
    endtask

    // N strobes at base and up, carrying the low N bytes
    task automatic storeAndCheck(input int len, input logic [31:0] addr, input int holdOff);
        logic [31:0] wdata;
        logic [31:0] rdata;
        wdata = $random(seed);
        wrAddrQ.delete();
        wrDataQ.delete();
        dataTxn(1'b1, len, addr, wdata, holdOff, rdata);
        checkValue("o_dataRdata", rdata, 32'h0);
        checkValue("o_memWrite count", wrAddrQ.size(), len);
        for (int i = 0; i < len; i++) begin
            if (i < wrAddrQ.size()) begin
                checkValue("o_memAddr", wrAddrQ[i], addr + 32'(i));
                checkValue("o_memWdata", 32'(wrDataQ[i]), 32'(wdata[8*i +: 8]));
            end
            refMem[8'(addr + 32'(i))] = wdata[8*i +: 8];
        end
    endtask

    task automatic pauseBurst();
        repeat (3) @(negedge clk);
        i_ioBufferFull = 1'b1;
        repeat (3) @(negedge clk);
        i_ioBufferFull = 1'b0;
        @(negedge clk);
        i_rdy = 1'b0;
        repeat (2) @(negedge clk);
        i_rdy = 1'b1;
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (totalErrors() == testErrBase) begin
            $display("test %s: pass", name);
        end else begin
            testsFailed++;
            $display("test %s: fail", name);
        end
        testErrBase = totalErrors();
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] inst;
        logic [31:0] rdata;
        int dataDone;
        int fetchDone;
        rst = 1'b1;
        i_rdy = 1'b1;
        i_ioBufferFull = 1'b0;
        i_fetchValid = 1'b0;
        i_fetchAddr = '0;
        i_fetchRespReady = 1'b0;
        i_dataValid = 1'b0;
        i_dataStore = 1'b0;
        i_dataLen = '0;
        i_dataAddr = '0;
        i_dataWdata = '0;
        i_dataRespReady = 1'b0;
        i_memRdata = '0;
        for (int a = 0; a < 256; a++) begin
            ramMem[8'(a)] = 8'(a * 7 + 3);
            refMem[8'(a)] = 8'(a * 7 + 3);
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;

        for (int n = 0; n < 4; n++) begin
            addr = $random(seed);
            fetchTxn(addr, 0, inst);
            checkValue("o_fetchInst", inst, expectedWord(addr, 4));
        end
        finishTest("fetch");

        loadAndCheck(1, $random(seed), 0);
        loadAndCheck(2, $random(seed), 0);
        loadAndCheck(4, $random(seed), 0);
        for (int n = 0; n < 6; n++) begin
            loadAndCheck(randomLen(), $random(seed), 0);
        end
        finishTest("load");

        // readback merges new bytes with untouched ones
        for (int len = 1; len <= 4; len = len * 2) begin
            addr = $random(seed);
            storeAndCheck(len, addr, 0);
            loadAndCheck(4, addr - 32'd1, 0);
        end
        finishTest("store");

        addr = $random(seed);
        fork
            begin
                dataTxn(1'b0, 4, addr + 32'h40, 32'h0, 0, rdata);
                dataDone = cycles;
            end
            begin
                fetchTxn(addr, 0, inst);
                fetchDone = cycles;
            end
        join
        checkValue("o_dataRdata", rdata, expectedWord(addr + 32'h40, 4));
        checkValue("o_fetchInst", inst, expectedWord(addr, 4));
        assert (dataDone < fetchDone) else begin
            $display("data request did not complete before the fetch");
            errorCount++;
        end
        finishTest("arbitration");

        addr = $random(seed);
        fork
            storeAndCheck(4, addr, 0);
            pauseBurst();
        join
        fork
            loadAndCheck(4, addr, 0);
            pauseBurst();
        join
        finishTest("pause");

        addr = $random(seed);
        loadAndCheck(4, addr, 4);
        storeAndCheck(2, addr, 3);
        loadAndCheck(4, addr, 2);
        fetchTxn(addr, 3, inst);
        checkValue("o_fetchInst", inst, expectedWord(addr, 4));
        finishTest("back-pressure");

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 testsRun, testsRun - testsFailed, testsFailed, totalErrors());
        if (testsFailed == 0 && totalErrors() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        while (cycles < timeoutCycles) @(posedge clk);
        $display("timeout: run stopped after %0d cycles", cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- sim.f
+incdir+logic
logic/memCtrlPkg.sv
logic/reqArbiter.sv
logic/busSequencer.sv
logic/wordAssembler.sv
logic/memCtrl.sv
dv/memCtrl_asserts.sv
dv/memCtrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= memCtrl_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
